// File: hdl/mem_pkg.sv
package mem_pkg;

	// one ram word is one full bus beat
	localparam int WORD_W = 64;

	// one strobe bit per byte lane
	localparam int STRB_W = WORD_W / 8;

	// byte offset bits dropped from every address
	localparam int OFFSET_BITS = $clog2(STRB_W);

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [STRB_W-1:0] strb_t;

	// ram geometry defaults, top level overrides these
	localparam int DEFAULT_DEPTH = 1024;
	localparam logic [31:0] DEFAULT_BASE = 32'h8000_0000;

endpackage

// File: hdl/axi_pkg.sv
package axi_pkg;

	// byte address width on the ar and aw channels
	localparam int ADDR_W = 32;

	// response code carried on r and b
	typedef logic [1:0] resp_t;

	// normal completion
	localparam resp_t OKAY = 2'b00;
	// address decoded but outside the ram
	localparam resp_t SLVERR = 2'b10;

	// read address beat
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
	} ar_t;

	// write address beat
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
	} aw_t;

	// write data beat
	// data and strobe sized from the ram word
	typedef struct packed {
		mem_pkg::word_t data;
		mem_pkg::strb_t strb;
	} w_t;

	// read response beat
	// data is zero when resp is SLVERR
	typedef struct packed {
		mem_pkg::word_t data;
		resp_t resp;
	} r_t;

	// write response beat
	typedef struct packed {
		resp_t resp;
	} b_t;

	// valid and ready travel as separate wires beside these payloads
	// one outstanding beat per channel

endpackage

// File: hdl/sram_array.sv
`timescale 1ns/1ns

module sram_array #(
	parameter int depth = mem_pkg::DEFAULT_DEPTH,
	localparam int idx_w = $clog2(depth)
) (
	input logic clk,
	input logic rd_en,
	input logic [idx_w-1:0] rd_index,
	output mem_pkg::word_t rd_data,
	input logic wr_en,
	input logic [idx_w-1:0] wr_index,
	input mem_pkg::word_t wr_data,
	input mem_pkg::strb_t wr_strb
);

	// bits per strobe lane
	localparam int lane_w = mem_pkg::WORD_W / mem_pkg::STRB_W;

	// storage, contents undefined until written
	mem_pkg::word_t mem [depth];

	// registered read
	// data appears the cycle after rd_en
	// a same-edge write to the same word is not seen here
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_index];
		end
	end

	// byte-strobed write
	// lanes with a clear strobe bit keep their old bytes
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int b = 0; b < mem_pkg::STRB_W; b++) begin
				if (wr_strb[b]) begin
					mem[wr_index][b*lane_w +: lane_w] <= wr_data[b*lane_w +: lane_w];
				end
			end
		end
	end

	// controller range check keeps both ports inside the array
	a_rd_in_range: assert property (@(posedge clk)
		rd_en |-> (32'(rd_index) < 32'(depth)));
	a_wr_in_range: assert property (@(posedge clk)
		wr_en |-> (32'(wr_index) < 32'(depth)));

endmodule

// File: hdl/rsp_slot.sv
`timescale 1ns/1ns

module rsp_slot #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic rst,
	input logic load,
	input payload_t payload_in,
	output logic full,
	output logic valid,
	input logic ready,
	output payload_t payload
);

	// one held response
	logic full_q;
	payload_t payload_q;

	// full toward the controller, valid toward the master, same flop
	assign full = full_q;
	assign valid = full_q;
	assign payload = payload_q;

	// occupancy
	// load wins, controller never loads while full
	always_ff @(posedge clk) begin
		if (rst) begin
			full_q <= 1'b0;
		end else if (load) begin
			full_q <= 1'b1;
		end else if (full_q && ready) begin
			full_q <= 1'b0;
		end
	end

	// response payload
	always_ff @(posedge clk) begin
		if (load) begin
			payload_q <= payload_in;
		end
	end

	// a stalled response stays up and unchanged until taken
	a_hold_stable: assert property (@(posedge clk) disable iff (rst)
		(valid && !ready) |=> (valid && $stable(payload)));

endmodule

// File: hdl/sram_ctrl.sv
`timescale 1ns/1ns

module sram_ctrl #(
	parameter int depth = mem_pkg::DEFAULT_DEPTH,
	parameter logic [31:0] base_addr = mem_pkg::DEFAULT_BASE,
	localparam int idx_w = $clog2(depth)
) (
	input logic clk,
	input logic rst,
	input logic ar_valid,
	input axi_pkg::ar_t ar,
	output logic ar_ready,
	input logic aw_valid,
	input axi_pkg::aw_t aw,
	input logic w_valid,
	input axi_pkg::w_t w,
	output logic aw_w_ready,
	output logic rd_en,
	output logic [idx_w-1:0] rd_index,
	input mem_pkg::word_t rd_data,
	output logic wr_en,
	output logic [idx_w-1:0] wr_index,
	output mem_pkg::word_t wr_data,
	output mem_pkg::strb_t wr_strb,
	output logic r_load,
	output axi_pkg::r_t r_payload,
	input logic r_full,
	output logic b_load,
	output axi_pkg::b_t b_payload,
	input logic b_full
);

	typedef enum logic [1:0] {
		rd_idle,
		rd_ram,
		rd_load
	} rd_state_t;

	typedef enum logic {
		wr_idle,
		wr_commit
	} wr_state_t;

	rd_state_t rd_state;
	wr_state_t wr_state;

	// word offset from base, wraps high for addresses below base
	logic [31:0] ar_word;
	logic [31:0] aw_word;
	logic ar_ok;
	logic aw_ok;
	logic ar_fire;
	logic aw_fire;

	// request captured at acceptance
	logic [idx_w-1:0] rd_idx_q;
	logic rd_err_q;
	logic [idx_w-1:0] wr_idx_q;
	logic wr_err_q;
	mem_pkg::word_t wr_data_q;
	mem_pkg::strb_t wr_strb_q;

	assign ar_word = (ar.addr - base_addr) >> mem_pkg::OFFSET_BITS;
	assign aw_word = (aw.addr - base_addr) >> mem_pkg::OFFSET_BITS;
	assign ar_ok = ar_word < 32'(depth);
	assign aw_ok = aw_word < 32'(depth);

	// accept only when idle and the response slot is free
	assign ar_ready = (rd_state == rd_idle) && !r_full;
	assign aw_w_ready = (wr_state == wr_idle) && !b_full;
	assign ar_fire = ar_valid && ar_ready;
	// address and data must arrive together
	assign aw_fire = aw_valid && w_valid && aw_w_ready;

	// ram read port, skipped for out-of-range reads
	assign rd_en = (rd_state == rd_ram) && !rd_err_q;
	assign rd_index = rd_idx_q;

	// ram data is valid in the load state
	assign r_load = rd_state == rd_load;
	assign r_payload = '{
		data: rd_err_q ? '0 : rd_data,
		resp: rd_err_q ? axi_pkg::SLVERR : axi_pkg::OKAY
	};

	// ram write and b response share the commit cycle
	assign wr_en = (wr_state == wr_commit) && !wr_err_q;
	assign wr_index = wr_idx_q;
	assign wr_data = wr_data_q;
	assign wr_strb = wr_strb_q;
	assign b_load = wr_state == wr_commit;
	assign b_payload = '{resp: wr_err_q ? axi_pkg::SLVERR : axi_pkg::OKAY};

	// read FSM, idle then ram read then slot load
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= rd_idle;
		end else begin
			case (rd_state)
				rd_idle: begin
					if (ar_fire) begin
						rd_state <= rd_ram;
					end
				end
				rd_ram: rd_state <= rd_load;
				rd_load: rd_state <= rd_idle;
				default: rd_state <= rd_idle;
			endcase
		end
	end

	// write FSM, one commit cycle per accepted beat
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_state <= wr_idle;
		end else if (wr_state == wr_idle) begin
			if (aw_fire) begin
				wr_state <= wr_commit;
			end
		end else begin
			wr_state <= wr_idle;
		end
	end

	// request capture
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			rd_idx_q <= ar_word[idx_w-1:0];
			rd_err_q <= !ar_ok;
		end
		if (aw_fire) begin
			wr_idx_q <= aw_word[idx_w-1:0];
			wr_err_q <= !aw_ok;
			wr_data_q <= w.data;
			wr_strb_q <= w.strb;
		end
	end

	// a ram write only ever follows an accepted in-range beat
	a_no_oob_write: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> $past(aw_fire && aw_ok));

	// the read slot is always empty when the read FSM loads it
	a_no_load_full: assert property (@(posedge clk) disable iff (rst)
		r_load |-> !r_full);

endmodule

// File: hdl/sram_slave.sv
`timescale 1ns/1ns

module sram_slave #(
	parameter int depth = mem_pkg::DEFAULT_DEPTH,
	parameter logic [31:0] base_addr = mem_pkg::DEFAULT_BASE,
	localparam int idx_w = $clog2(depth)
) (
	input logic clk,
	input logic rst,
	input logic arvalid,
	input axi_pkg::ar_t araddr,
	output logic arready,
	output logic rvalid,
	output axi_pkg::r_t rdata,
	input logic rready,
	input logic awvalid,
	input axi_pkg::aw_t awaddr,
	input logic wvalid,
	input axi_pkg::w_t wdata,
	output logic awready,
	output logic wready,
	output logic bvalid,
	output axi_pkg::b_t bresp,
	input logic bready
);

	// ram ports
	logic rd_en;
	logic [idx_w-1:0] rd_index;
	mem_pkg::word_t rd_data;
	logic wr_en;
	logic [idx_w-1:0] wr_index;
	mem_pkg::word_t wr_data;
	mem_pkg::strb_t wr_strb;

	// response slot loads
	logic r_load;
	axi_pkg::r_t r_payload;
	logic r_full;
	logic b_load;
	axi_pkg::b_t b_payload;
	logic b_full;

	// aw and w are accepted as a pair
	logic aw_w_ready;

	assign awready = aw_w_ready;
	assign wready = aw_w_ready;

	sram_ctrl #(
		.depth(depth),
		.base_addr(base_addr)
	) u_ctrl (
		.clk(clk),
		.rst(rst),
		.ar_valid(arvalid),
		.ar(araddr),
		.ar_ready(arready),
		.aw_valid(awvalid),
		.aw(awaddr),
		.w_valid(wvalid),
		.w(wdata),
		.aw_w_ready(aw_w_ready),
		.rd_en(rd_en),
		.rd_index(rd_index),
		.rd_data(rd_data),
		.wr_en(wr_en),
		.wr_index(wr_index),
		.wr_data(wr_data),
		.wr_strb(wr_strb),
		.r_load(r_load),
		.r_payload(r_payload),
		.r_full(r_full),
		.b_load(b_load),
		.b_payload(b_payload),
		.b_full(b_full)
	);

	sram_array #(
		.depth(depth)
	) u_array (
		.clk(clk),
		.rd_en(rd_en),
		.rd_index(rd_index),
		.rd_data(rd_data),
		.wr_en(wr_en),
		.wr_index(wr_index),
		.wr_data(wr_data),
		.wr_strb(wr_strb)
	);

	// read response, data plus code
	rsp_slot #(
		.payload_t(axi_pkg::r_t)
	) u_r_slot (
		.clk(clk),
		.rst(rst),
		.load(r_load),
		.payload_in(r_payload),
		.full(r_full),
		.valid(rvalid),
		.ready(rready),
		.payload(rdata)
	);

	// write response, code only
	rsp_slot #(
		.payload_t(axi_pkg::b_t)
	) u_b_slot (
		.clk(clk),
		.rst(rst),
		.load(b_load),
		.payload_in(b_payload),
		.full(b_full),
		.valid(bvalid),
		.ready(bready),
		.payload(bresp)
	);

endmodule

// File: testbench/sram_slave_tb.sv
`timescale 1ns/1ns

module sram_slave_tb;

	localparam int depth = mem_pkg::DEFAULT_DEPTH;
	localparam logic [31:0] base_addr = mem_pkg::DEFAULT_BASE;
	// the six tests take roughly 1100 cycles
	localparam int timeout_cycles = 4000;

	logic clk = 1'b0;
	logic rst;
	logic arvalid;
	axi_pkg::ar_t araddr;
	logic arready;
	logic rvalid;
	axi_pkg::r_t rdata;
	logic rready;
	logic awvalid;
	axi_pkg::aw_t awaddr;
	logic wvalid;
	axi_pkg::w_t wdata;
	logic awready;
	logic wready;
	logic bvalid;
	axi_pkg::b_t bresp;
	logic bready;

	// expected ram contents, keyed by word index
	mem_pkg::word_t model [int];
	int errors;
	int checks;
	int cycles;
	// cycles from acceptance to valid, last transaction
	int b_latency;
	int r_latency;

	sram_slave #(
		.depth(depth),
		.base_addr(base_addr)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.arvalid(arvalid),
		.araddr(araddr),
		.arready(arready),
		.rvalid(rvalid),
		.rdata(rdata),
		.rready(rready),
		.awvalid(awvalid),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wdata(wdata),
		.awready(awready),
		.wready(wready),
		.bvalid(bvalid),
		.bresp(bresp),
		.bready(bready)
	);

	always #4 clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= timeout_cycles) begin
			$display("timeout: tests still running after %0d cycles", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		assert (act === exp) else begin
			$display("ERR %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	function automatic logic [31:0] addr_of(input int idx);
		return base_addr + 32'(idx) * 32'd8;
	endfunction

	// low three bits dropped, offset from base
	function automatic logic [31:0] word_of(input logic [31:0] byte_addr);
		return (byte_addr - base_addr) >> 3;
	endfunction

	function automatic axi_pkg::resp_t resp_for(input logic [31:0] byte_addr);
		return (word_of(byte_addr) < 32'(depth)) ? axi_pkg::OKAY : axi_pkg::SLVERR;
	endfunction

	// new bytes where the strobe is set, old bytes elsewhere
	function automatic mem_pkg::word_t merge_bytes(input mem_pkg::word_t old_word,
			input mem_pkg::word_t wr_word, input mem_pkg::strb_t strb);
		mem_pkg::word_t res;
		res = old_word;
		for (int i = 0; i < 8; i++) begin
			if (strb[i]) begin
				res[i*8 +: 8] = wr_word[i*8 +: 8];
			end
		end
		return res;
	endfunction

	// out-of-range writes leave the model alone
	function automatic void model_write(input logic [31:0] byte_addr,
			input mem_pkg::word_t data, input mem_pkg::strb_t strb);
		int w;
		mem_pkg::word_t old_word;
		w = int'(word_of(byte_addr));
		old_word = '0;
		if (resp_for(byte_addr) == axi_pkg::OKAY) begin
			if (model.exists(w)) begin
				old_word = model[w];
			end
			model[w] = merge_bytes(old_word, data, strb);
		end
	endfunction

	// zero outside the ram
	function automatic mem_pkg::word_t model_read(input logic [31:0] byte_addr);
		int w;
		w = int'(word_of(byte_addr));
		if (resp_for(byte_addr) == axi_pkg::SLVERR || !model.exists(w)) begin
			return '0;
		end
		return model[w];
	endfunction

	// returns one ns after the accepting edge
	task automatic send_write(input logic [31:0] byte_addr, input mem_pkg::word_t data,
			input mem_pkg::strb_t strb);
		awvalid = 1'b1;
		wvalid = 1'b1;
		awaddr = '{addr: byte_addr};
		wdata = '{data: data, strb: strb};
		while (!(awready && wready)) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
	endtask

	task automatic send_read(input logic [31:0] byte_addr);
		arvalid = 1'b1;
		araddr = '{addr: byte_addr};
		while (!arready) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
		arvalid = 1'b0;
	endtask

	task automatic take_b(input axi_pkg::resp_t exp_resp);
		int lat;
		lat = 0;
		while (!bvalid) begin
			@(posedge clk);
			#1;
			lat++;
		end
		b_latency = lat;
		check_val("bresp.resp", 64'(exp_resp), 64'(bresp.resp));
		bready = 1'b1;
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic take_r(input mem_pkg::word_t exp_data, input axi_pkg::resp_t exp_resp);
		int lat;
		lat = 0;
		while (!rvalid) begin
			@(posedge clk);
			#1;
			lat++;
		end
		r_latency = lat;
		check_val("rdata.data", exp_data, rdata.data);
		check_val("rdata.resp", 64'(exp_resp), 64'(rdata.resp));
		rready = 1'b1;
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	task automatic write_word(input logic [31:0] byte_addr, input mem_pkg::word_t data,
			input mem_pkg::strb_t strb);
		model_write(byte_addr, data, strb);
		send_write(byte_addr, data, strb);
		take_b(resp_for(byte_addr));
	endtask

	task automatic read_word(input logic [31:0] byte_addr);
		send_read(byte_addr);
		take_r(model_read(byte_addr), resp_for(byte_addr));
	endtask

	task automatic report_test(input string name, input int start_errors);
		$display("test %s: %0d errors", name, errors - start_errors);
	endtask

	task automatic reset_state();
		int start;
		start = errors;
		check_val("rvalid", 64'd0, 64'(rvalid));
		check_val("bvalid", 64'd0, 64'(bvalid));
		@(posedge clk);
		#1;
		check_val("arready", 64'd1, 64'(arready));
		check_val("awready", 64'd1, 64'(awready));
		check_val("wready", 64'd1, 64'(wready));
		report_test("reset_state", start);
	endtask

	task automatic write_then_read();
		int start;
		start = errors;
		write_word(addr_of(3), 64'h0123_4567_89ab_cdef, 8'hff);
		check_val("b latency", 64'd1, 64'(b_latency));
		read_word(addr_of(3));
		check_val("r latency", 64'd2, 64'(r_latency));
		report_test("write_then_read", start);
	endtask

	task automatic strobe_merge();
		int start;
		start = errors;
		write_word(addr_of(7), 64'h1111_2222_3333_4444, 8'hff);
		// lanes 0, 2, 5 and 7 replaced
		write_word(addr_of(7), 64'haaaa_bbbb_cccc_dddd, 8'ha5);
		read_word(addr_of(7));
		report_test("strobe_merge", start);
	endtask

	task automatic out_of_range();
		int start;
		logic [31:0] oob;
		start = errors;
		// first word past the end, aliases index 0 if truncated
		oob = base_addr + 32'(depth) * 32'd8;
		write_word(addr_of(0), 64'hfeed_face_cafe_beef, 8'hff);
		write_word(oob, 64'hdead_dead_dead_dead, 8'hff);
		read_word(oob);
		read_word(addr_of(0));
		report_test("out_of_range", start);
	endtask

	task automatic back_pressure();
		int start;
		mem_pkg::word_t exp_data;
		start = errors;
		model_write(addr_of(9), 64'h0f0f_1234_5678_f0f0, 8'hff);
		exp_data = model_read(addr_of(9));
		send_write(addr_of(9), 64'h0f0f_1234_5678_f0f0, 8'hff);
		send_read(addr_of(9));
		while (!(rvalid && bvalid)) begin
			@(posedge clk);
			#1;
		end
		// both responses stalled
		repeat (5) begin
			@(posedge clk);
			#1;
			check_val("rvalid", 64'd1, 64'(rvalid));
			check_val("bvalid", 64'd1, 64'(bvalid));
			check_val("rdata.data", exp_data, rdata.data);
			check_val("rdata.resp", 64'(axi_pkg::OKAY), 64'(rdata.resp));
			check_val("bresp.resp", 64'(axi_pkg::OKAY), 64'(bresp.resp));
			check_val("arready", 64'd0, 64'(arready));
			check_val("awready", 64'd0, 64'(awready));
			check_val("wready", 64'd0, 64'(wready));
		end
		take_r(exp_data, axi_pkg::OKAY);
		take_b(axi_pkg::OKAY);
		check_val("arready", 64'd1, 64'(arready));
		check_val("awready", 64'd1, 64'(awready));
		report_test("back_pressure", start);
	endtask

	task automatic random_traffic();
		int start;
		int idx;
		mem_pkg::word_t data;
		mem_pkg::strb_t strb;
		start = errors;
		// fill a 32-word window so every read has a known word
		for (int i = 0; i < 32; i++) begin
			write_word(addr_of(512 + i), {$urandom(), $urandom()}, 8'hff);
		end
		for (int n = 0; n < 200; n++) begin
			idx = 512 + int'($urandom() % 32);
			if ($urandom() % 2 == 0) begin
				data = {$urandom(), $urandom()};
				strb = 8'($urandom());
				write_word(addr_of(idx), data, strb);
			end else begin
				read_word(addr_of(idx));
			end
		end
		report_test("random_traffic", start);
	endtask

	initial begin
		void'($urandom(32'hc24c_0f9d));
		rst = 1'b1;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		reset_state();
		write_then_read();
		strobe_merge();
		out_of_range();
		back_pressure();
		random_traffic();
		$display("summary: 6 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: sram_slave.f
hdl/mem_pkg.sv
hdl/axi_pkg.sv
hdl/sram_array.sv
hdl/rsp_slot.sv
hdl/sram_ctrl.sv
hdl/sram_slave.sv
testbench/sram_slave_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the sram_slave testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module sram_slave_tb \
	-f sram_slave.f \
	-o sram_slave_sim

./obj_dir/sram_slave_sim | tee sim.log

# the log decides the result
if grep -q "TESTBENCH PASSED" sim.log; then
	echo "simulation result: pass"
else
	echo "simulation result: fail"
	exit 1
fi
